// File: build.f
source/core_pkg.sv
source/alu.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
testbench/cpu_assert.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [core_pkg::XLEN-1:0] a,
	input  logic [core_pkg::XLEN-1:0] b,
	input  core_pkg::alu_fn_t         fn,
	output logic [core_pkg::XLEN-1:0] y
);
	import core_pkg::*;

	logic [4:0] shamt;
	logic       lt;

	// Shift amount from the low bits only
	assign shamt = b[4:0];
	// Signed compare
	assign lt = $signed(a) < $signed(b);

	always_comb
	begin
		case (fn)
			FN_ADD:
				y = a + b;
			FN_SUB:
				y = a - b;
			FN_AND:
				y = a & b;
			FN_OR:
				y = a | b;
			FN_XOR:
				y = a ^ b;
			FN_SLT:
				y = {{(XLEN-1){1'b0}}, lt};
			FN_SLL:
				y = a << shamt;
			FN_SRL:
				y = a >> shamt;
			// Unlisted codes give zero
			default:
				y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int XLEN       = 32;
	localparam int PC_W       = 6;
	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int NREGS      = 32;
	localparam int REG_W      = 5;
	// Link register for jump-and-link
	localparam int REG_LINK   = 31;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes and function codes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_ALU  = 2'b00,
		OP_ALUI = 2'b01,
		OP_MEM  = 2'b10,
		OP_CTRL = 2'b11
	} op_t;

	typedef enum logic [3:0] {
		FN_ADD = 4'd0,
		FN_SUB = 4'd1,
		FN_AND = 4'd2,
		FN_OR  = 4'd3,
		FN_XOR = 4'd4,
		FN_SLT = 4'd5,
		FN_SLL = 4'd6,
		FN_SRL = 4'd7
	} alu_fn_t;

	typedef enum logic [3:0] {
		BEQZ = 4'd0,
		BLTZ = 4'd1,
		JMP  = 4'd2,
		JAL  = 4'd3,
		HALT = 4'd4
	} ctrl_fn_t;

	// Memory class functions
	localparam logic [3:0] MEM_LOAD  = 4'd0;
	localparam logic [3:0] MEM_STORE = 4'd1;

	// What a retired instruction was
	typedef enum logic [2:0] {
		KIND_ALU   = 3'd0,
		KIND_LOAD  = 3'd1,
		KIND_STORE = 3'd2,
		KIND_CTRL  = 3'd3,
		KIND_HALT  = 3'd4
	} kind_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word, two views of the same 32 bits
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		op_t              op;
		logic [3:0]       fn;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [15:0]      imm;
	} imm_fmt_t;

	typedef struct packed {
		op_t         op;
		logic [3:0]  fn;
		logic [25:0] target;
	} jmp_fmt_t;

	typedef union packed {
		imm_fmt_t imm;
		jmp_fmt_t jmp;
	} instr_u;

	////////////////////////////////////////////////////////////////////////////
	// Stage records
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic            valid;
		logic [PC_W-1:0] pc;
		instr_u          instr;
	} fd_t;

	typedef struct packed {
		logic             valid;
		logic [PC_W-1:0]  pc;
		op_t              op;
		logic [3:0]       fn;
		logic [REG_W-1:0] dest;
		logic             we;
		logic [XLEN-1:0]  rs_val;
		logic [XLEN-1:0]  rt_val;
		logic [XLEN-1:0]  imm;
	} de_t;

	typedef struct packed {
		logic             valid;
		logic [PC_W-1:0]  pc;
		kind_t            kind;
		logic [REG_W-1:0] dest;
		logic             we;
		logic [XLEN-1:0]  result;
		logic [XLEN-1:0]  store_data;
		logic             mem;
	} em_t;

	typedef struct packed {
		logic             we;
		logic [REG_W-1:0] dest;
		logic [XLEN-1:0]  data;
	} wb_t;

	// Store reports the stored value in data
	typedef struct packed {
		logic [PC_W-1:0]  pc;
		kind_t            kind;
		logic             we;
		logic [REG_W-1:0] dest;
		logic [XLEN-1:0]  data;
	} retire_t;

	typedef struct packed {
		logic            taken;
		logic [PC_W-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      run,
	input  logic                      prog_we,
	input  logic [core_pkg::PC_W-1:0] prog_addr,
	input  core_pkg::instr_u          prog_data,
	output logic                      retire_valid,
	output core_pkg::retire_t         retire,
	output logic                      halted
);
	import core_pkg::*;

	fd_t       fd;
	de_t       de;
	em_t       em;
	wb_t       wb;
	redirect_t redirect;
	logic      stall;
	logic      halt_seen;

	fetch_stage u_fetch (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.stall     (stall),
		.redirect  (redirect),
		.halt_seen (halt_seen),
		.fd        (fd)
	);

	// Hazard check sees the execute and memory stage registers
	decode_stage u_decode (
		.clk      (clk),
		.rst      (rst),
		.fd       (fd),
		.wb       (wb),
		.redirect (redirect),
		.ex_busy  (de),
		.mem_busy (em),
		.stall    (stall),
		.de       (de)
	);

	execute_stage u_execute (
		.clk       (clk),
		.rst       (rst),
		.de        (de),
		.redirect  (redirect),
		.halt_seen (halt_seen),
		.em        (em)
	);

	memory_stage u_memory (
		.clk          (clk),
		.rst          (rst),
		.em           (em),
		.wb           (wb),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted)
	);

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::fd_t       fd,
	input  core_pkg::wb_t       wb,
	input  core_pkg::redirect_t redirect,
	input  core_pkg::de_t       ex_busy,
	input  core_pkg::em_t       mem_busy,
	output logic                stall,
	output core_pkg::de_t       de
);
	import core_pkg::*;

	instr_u           instr;
	logic [REG_W-1:0] rs;
	logic [REG_W-1:0] rt;
	logic [XLEN-1:0]  rs_val;
	logic [XLEN-1:0]  rt_val;
	logic             uses_rs;
	logic             uses_rt;
	logic             is_jump;
	de_t              de_next;

	// Register still on its way to the register file
	function automatic logic pending(input logic [REG_W-1:0] r, input de_t ex, input em_t mm);
		return (ex.valid && ex.we && ex.dest == r) || (mm.valid && mm.we && mm.dest == r);
	endfunction

	assign instr = fd.instr;
	assign rs    = instr.imm.rs;
	assign rt    = instr.imm.rt;

	register_file u_regs (
		.clk (clk),
		.rst (rst),
		.wb  (wb),
		.ra  (rs),
		.rb  (rt),
		.da  (rs_val),
		.db  (rt_val)
	);

	// Jumps take the absolute target view
	assign is_jump = instr.jmp.op == OP_CTRL && (instr.jmp.fn == JMP || instr.jmp.fn == JAL);

	////////////////////////////////////////////////////////////////////////////
	// Field decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		de_next        = '0;
		de_next.valid  = fd.valid;
		de_next.pc     = fd.pc;
		de_next.op     = instr.imm.op;
		de_next.fn     = instr.imm.fn;
		de_next.rs_val = rs_val;
		de_next.rt_val = rt_val;
		uses_rs        = 1'b0;
		uses_rt        = 1'b0;
		if (is_jump)
			de_next.imm = {{(XLEN-PC_W){1'b0}}, instr.jmp.target[PC_W-1:0]};
		else
			de_next.imm = {{(XLEN-16){instr.imm.imm[15]}}, instr.imm.imm};
		case (instr.imm.op)
			OP_ALU:
			begin
				// Two-address form, rs is also the destination
				de_next.dest = rs;
				de_next.we   = 1'b1;
				uses_rs      = 1'b1;
				uses_rt      = 1'b1;
			end
			OP_ALUI:
			begin
				de_next.dest = rs;
				de_next.we   = 1'b1;
				uses_rs      = 1'b1;
			end
			OP_MEM:
			begin
				uses_rs = 1'b1;
				if (instr.imm.fn == MEM_STORE)
					uses_rt = 1'b1;
				else
				begin
					de_next.dest = rt;
					de_next.we   = 1'b1;
				end
			end
			default:
			begin
				// Control: branches test rs, JAL writes the link
				uses_rs = instr.imm.fn == BEQZ || instr.imm.fn == BLTZ;
				if (instr.jmp.fn == JAL)
				begin
					de_next.dest = REG_LINK[REG_W-1:0];
					de_next.we   = 1'b1;
				end
			end
		endcase
	end

	// Interlock against results not yet written
	assign stall = fd.valid && !redirect.taken &&
		((uses_rs && pending(rs, ex_busy, mem_busy)) ||
		(uses_rt && pending(rt, ex_busy, mem_busy)));

	always_ff @(posedge clk)
	begin
		if (rst)
			de <= '0;
		else if (stall || redirect.taken)
			de <= '0;
		else
			de <= de_next;
	end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::de_t       de,
	output core_pkg::redirect_t redirect,
	output logic                halt_seen,
	output core_pkg::em_t       em
);
	import core_pkg::*;

	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_y;
	logic [PC_W-1:0] pc_inc;
	alu_fn_t         alu_fn;
	ctrl_fn_t        cfn;
	logic            is_ctrl;
	em_t             em_next;

	assign pc_inc = de.pc + 1'b1;
	assign cfn    = ctrl_fn_t'(de.fn);

	// Register form uses rt, everything else the immediate
	assign alu_b  = (de.op == OP_ALU) ? de.rt_val : de.imm;
	// Memory address is rs plus offset
	assign alu_fn = (de.op == OP_ALU || de.op == OP_ALUI) ? alu_fn_t'(de.fn) : FN_ADD;

	alu u_alu (
		.a  (de.rs_val),
		.b  (alu_b),
		.fn (alu_fn),
		.y  (alu_y)
	);

	////////////////////////////////////////////////////////////////////////////
	// Branch resolution, straight from the input register
	////////////////////////////////////////////////////////////////////////////

	assign is_ctrl   = de.valid && de.op == OP_CTRL;
	assign halt_seen = is_ctrl && cfn == HALT;

	always_comb
	begin
		redirect = '0;
		if (is_ctrl)
		begin
			case (cfn)
				BEQZ:
				begin
					redirect.taken  = de.rs_val == '0;
					redirect.target = pc_inc + de.imm[PC_W-1:0];
				end
				BLTZ:
				begin
					redirect.taken  = de.rs_val[XLEN-1];
					redirect.target = pc_inc + de.imm[PC_W-1:0];
				end
				JMP, JAL:
				begin
					redirect.taken  = 1'b1;
					redirect.target = de.imm[PC_W-1:0];
				end
				HALT:
				begin
					// Flush the younger two, fetch stops anyway
					redirect.taken  = 1'b1;
					redirect.target = de.pc;
				end
				default:
					redirect = '0;
			endcase
		end
	end

	always_comb
	begin
		em_next.valid      = de.valid;
		em_next.pc         = de.pc;
		em_next.dest       = de.dest;
		em_next.we         = de.we;
		em_next.result     = alu_y;
		em_next.store_data = de.rt_val;
		em_next.mem        = de.op == OP_MEM;
		em_next.kind       = KIND_ALU;
		case (de.op)
			OP_MEM:
				em_next.kind = (de.fn == MEM_STORE) ? KIND_STORE : KIND_LOAD;
			OP_CTRL:
			begin
				em_next.kind   = (cfn == HALT) ? KIND_HALT : KIND_CTRL;
				// Link value for JAL
				em_next.result = {{(XLEN-PC_W){1'b0}}, pc_inc};
			end
			default:
				em_next.kind = KIND_ALU;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			em <= '0;
		else
			em <= em_next;
	end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      run,
	input  logic                      prog_we,
	input  logic [core_pkg::PC_W-1:0] prog_addr,
	input  core_pkg::instr_u          prog_data,
	input  logic                      stall,
	input  core_pkg::redirect_t       redirect,
	input  logic                      halt_seen,
	output core_pkg::fd_t             fd
);
	import core_pkg::*;

	instr_u          imem [IMEM_DEPTH];
	logic [PC_W-1:0] pc;
	logic            stopped;
	logic            issue;

	// Program load port, driven only while run is low
	always_ff @(posedge clk)
	begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	// Nothing issues before run or once a halt went by
	assign issue = run && !stopped && !halt_seen;

	////////////////////////////////////////////////////////////////////////////
	// PC and registered instruction read
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc      <= '0;
			stopped <= 1'b0;
			fd      <= '0;
		end
		else
		begin
			// Sticky until reset
			if (halt_seen)
				stopped <= 1'b1;
			if (redirect.taken)
			begin
				// Drop the younger word, restart at target
				pc       <= redirect.target;
				fd.valid <= 1'b0;
			end
			else if (!stall)
			begin
				fd.valid <= issue;
				fd.pc    <= pc;
				fd.instr <= imem[pc];
				if (issue)
					pc <= pc + 1'b1;
			end
			// Stall holds PC and output as they are
		end
	end

endmodule

`default_nettype wire

// File: source/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  logic              clk,
	input  logic              rst,
	input  core_pkg::em_t     em,
	output core_pkg::wb_t     wb,
	output logic              retire_valid,
	output core_pkg::retire_t retire,
	output logic              halted
);
	import core_pkg::*;

	localparam int DADDR_W = $clog2(DMEM_DEPTH);

	logic [XLEN-1:0]    dmem [DMEM_DEPTH];
	logic [DADDR_W-1:0] addr;
	logic [XLEN-1:0]    load_data;
	logic               is_store;

	// Word index from the low address bits
	assign addr      = em.result[DADDR_W-1:0];
	assign load_data = dmem[addr];
	assign is_store  = em.valid && em.mem && em.kind == KIND_STORE;

	always_ff @(posedge clk)
	begin
		if (is_store)
			dmem[addr] <= em.store_data;
	end

	// Write-back goes out in the same cycle
	always_comb
	begin
		wb.we   = em.valid && em.we;
		wb.dest = em.dest;
		wb.data = (em.mem && em.kind == KIND_LOAD) ? load_data : em.result;
	end

	////////////////////////////////////////////////////////////////////////////
	// Retire report, one cycle after the access
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			retire_valid <= 1'b0;
			retire       <= '0;
			halted       <= 1'b0;
		end
		else
		begin
			retire_valid <= em.valid;
			retire.pc    <= em.pc;
			retire.kind  <= em.kind;
			retire.we    <= em.we;
			retire.dest  <= em.dest;
			retire.data  <= is_store ? em.store_data : wb.data;
			// Rises the cycle after halt retires, held until reset
			if (retire_valid && retire.kind == KIND_HALT)
				halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                       clk,
	input  logic                       rst,
	input  core_pkg::wb_t              wb,
	input  logic [core_pkg::REG_W-1:0] ra,
	input  logic [core_pkg::REG_W-1:0] rb,
	output logic [core_pkg::XLEN-1:0]  da,
	output logic [core_pkg::XLEN-1:0]  db
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [NREGS];

	// Single write port from the memory stage
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (wb.we)
			regs[wb.dest] <= wb.data;
	end

	// Write-through on a same-cycle read
	assign da = (wb.we && wb.dest == ra) ? wb.data : regs[ra];
	assign db = (wb.we && wb.dest == rb) ? wb.data : regs[rb];

endmodule

`default_nettype wire

// File: testbench/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assert (
	input logic clk,
	input logic rst,
	input logic retire_valid,
	input logic halted
);

	// Nothing retires while reset is held
	a_reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !retire_valid)
		else $error("retire_valid high during reset");

	// Sticky until reset
	a_halted_sticky: assert property (@(posedge clk) halted && !rst |=> halted)
		else $error("halted dropped without reset");

	// Halt is the last retirement
	a_no_retire_after_halt: assert property (@(posedge clk) halted |-> !retire_valid)
		else $error("retirement after halted");

endmodule

bind cpu_top cpu_assert u_assert (
	.clk          (clk),
	.rst          (rst),
	.retire_valid (retire_valid),
	.halted       (halted)
);

`default_nettype wire

// File: testbench/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
	parameter int MAX_ROWS = 64
) (
	input  logic              clk,
	input  logic              retire_valid,
	input  core_pkg::retire_t retire,
	input  logic              halted,
	input  logic              start,
	input  logic              check_end,
	input  logic              report,
	input  int                exp_first,
	input  int                exp_last,
	input  core_pkg::retire_t exp_tab [MAX_ROWS],
	output int                errors
);
	import core_pkg::*;

	int      idx = 0;
	int      last = 0;
	int      compared = 0;
	int      mismatches = 0;
	int      missing = 0;
	int      extra = 0;
	int      timing = 0;
	logic    halt_due = 1'b0;
	logic    halt_done = 1'b0;
	retire_t want;

	// One field against its expected value
	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h at time %0t", name, got, exp, $time);
			mismatches++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Retire stream against the expected list in order
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (start)
		begin
			idx       = exp_first;
			last      = exp_last;
			halt_due  = 1'b0;
			halt_done = 1'b0;
		end
		else
		begin
			// halted follows the halt retirement by one cycle
			if (halt_due)
			begin
				if (!halted)
				begin
					$display("halted did not rise after the halt retired");
					timing++;
				end
				halt_due  = 1'b0;
				halt_done = 1'b1;
			end
			else if (halted && !halt_done)
			begin
				$display("halted rose before the halt retired");
				timing++;
			end
			if (retire_valid)
			begin
				if (idx >= last)
				begin
					$display("Extra retirement at pc 0x%h after the expected list ended",
						retire.pc);
					extra++;
				end
				else
				begin
					want = exp_tab[idx];
					compared++;
					compare_field("retire.pc", 32'(retire.pc), 32'(want.pc));
					compare_field("retire.kind", 32'(retire.kind), 32'(want.kind));
					compare_field("retire.we", 32'(retire.we), 32'(want.we));
					// Dest only matters when a register is written
					if (want.we)
						compare_field("retire.dest", 32'(retire.dest), 32'(want.dest));
					if (want.we || want.kind == KIND_STORE)
						compare_field("retire.data", retire.data, want.data);
					if (want.kind == KIND_HALT)
						halt_due = 1'b1;
					idx++;
				end
			end
		end
		if (check_end)
		begin
			if (idx < last)
			begin
				$display("Missing retirement: %0d expected records never retired", last - idx);
				missing += last - idx;
			end
		end
		if (report)
			$display("Checks done: %0d compared, %0d mismatches, %0d missing, %0d extra, %0d halted timing",
				compared, mismatches, missing, extra, timing);
		errors <= mismatches + missing + extra + timing;
	end

endmodule

`default_nettype wire

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import core_pkg::*;

	localparam int MAX_ROWS = 64;

	logic            clk = 1'b0;
	logic            rst;
	logic            run;
	logic            prog_we;
	logic [PC_W-1:0] prog_addr;
	instr_u          prog_data;
	logic            retire_valid;
	retire_t         retire;
	logic            halted;
	logic            start;
	logic            check_end;
	logic            report;
	int              exp_first;
	int              exp_last;
	int              errors;

	// Program words and expected retire records tagged by program
	logic [31:0] words [MAX_ROWS];
	int          word_prog [MAX_ROWS];
	int          n_words = 0;
	retire_t     exp_tab [MAX_ROWS];
	int          exp_prog [MAX_ROWS];
	int          n_exp = 0;
	int          cycles = 0;
	int          limit = 0;

	always #2 clk = ~clk;

	cpu_top dut (
		.clk          (clk),
		.rst          (rst),
		.run          (run),
		.prog_we      (prog_we),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted)
	);

	cpu_checker #(.MAX_ROWS(MAX_ROWS)) chk (
		.clk          (clk),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted),
		.start        (start),
		.check_end    (check_end),
		.report       (report),
		.exp_first    (exp_first),
		.exp_last     (exp_last),
		.exp_tab      (exp_tab),
		.errors       (errors)
	);

	// Immediate format with jump targets in the low imm bits
	function automatic logic [31:0] encode(input op_t op, input logic [3:0] fn, input int rs,
		input int rt, input logic [15:0] imm);
		return {op, fn, rs[4:0], rt[4:0], imm};
	endfunction

	task automatic put_word(input int p, input logic [31:0] w);
		words[n_words]     = w;
		word_prog[n_words] = p;
		n_words++;
	endtask

	task automatic expect_retire(input int p, input int pc, input kind_t kind, input logic we,
		input int dest, input logic [31:0] data);
		exp_tab[n_exp]  = '{pc: pc[PC_W-1:0], kind: kind, we: we, dest: dest[4:0], data: data};
		exp_prog[n_exp] = p;
		n_exp++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program table
	////////////////////////////////////////////////////////////////////////////

	task automatic fill_table();
		// ALU, immediates, interlock, store then load
		put_word(0, encode(OP_ALUI, FN_ADD, 1, 0, 16'h0123));
		put_word(0, encode(OP_ALUI, FN_ADD, 2, 0, 16'hFFFD));
		put_word(0, encode(OP_ALUI, FN_ADD, 3, 0, 16'h0024));
		put_word(0, encode(OP_ALU, FN_ADD, 1, 2, 16'h0));
		put_word(0, encode(OP_ALUI, FN_ADD, 4, 0, 16'h00F0));
		put_word(0, encode(OP_ALU, FN_AND, 4, 1, 16'h0));
		put_word(0, encode(OP_ALUI, FN_ADD, 5, 0, 16'h0F0F));
		put_word(0, encode(OP_ALU, FN_OR, 5, 4, 16'h0));
		put_word(0, encode(OP_ALU, FN_XOR, 5, 1, 16'h0));
		put_word(0, encode(OP_ALU, FN_SUB, 5, 2, 16'h0));
		put_word(0, encode(OP_ALUI, FN_ADD, 6, 0, 16'h0001));
		put_word(0, encode(OP_ALU, FN_SLL, 6, 3, 16'h0));
		put_word(0, encode(OP_ALUI, FN_ADD, 7, 0, 16'hFF00));
		put_word(0, encode(OP_ALU, FN_SRL, 7, 3, 16'h0));
		put_word(0, encode(OP_ALUI, FN_ADD, 8, 0, 16'hFFFF));
		put_word(0, encode(OP_ALU, FN_SLT, 8, 1, 16'h0));
		put_word(0, encode(OP_ALUI, FN_ADD, 9, 0, 16'h0005));
		put_word(0, encode(OP_ALU, FN_SLT, 9, 2, 16'h0));
		put_word(0, encode(OP_MEM, MEM_STORE, 0, 5, 16'h000A));
		put_word(0, encode(OP_MEM, MEM_LOAD, 0, 10, 16'h000A));
		put_word(0, encode(OP_ALUI, FN_ADD, 10, 0, 16'hFFF0));
		put_word(0, encode(OP_CTRL, HALT, 0, 0, 16'h0));
		put_word(0, encode(OP_ALUI, FN_ADD, 11, 0, 16'h0001));
		expect_retire(0, 0, KIND_ALU, 1, 1, 32'h0000_0123);
		expect_retire(0, 1, KIND_ALU, 1, 2, 32'hFFFF_FFFD);
		expect_retire(0, 2, KIND_ALU, 1, 3, 32'h0000_0024);
		expect_retire(0, 3, KIND_ALU, 1, 1, 32'h0000_0120);
		expect_retire(0, 4, KIND_ALU, 1, 4, 32'h0000_00F0);
		expect_retire(0, 5, KIND_ALU, 1, 4, 32'h0000_0020);
		expect_retire(0, 6, KIND_ALU, 1, 5, 32'h0000_0F0F);
		expect_retire(0, 7, KIND_ALU, 1, 5, 32'h0000_0F2F);
		expect_retire(0, 8, KIND_ALU, 1, 5, 32'h0000_0E0F);
		expect_retire(0, 9, KIND_ALU, 1, 5, 32'h0000_0E12);
		expect_retire(0, 10, KIND_ALU, 1, 6, 32'h0000_0001);
		expect_retire(0, 11, KIND_ALU, 1, 6, 32'h0000_0010);
		expect_retire(0, 12, KIND_ALU, 1, 7, 32'hFFFF_FF00);
		expect_retire(0, 13, KIND_ALU, 1, 7, 32'h0FFF_FFF0);
		expect_retire(0, 14, KIND_ALU, 1, 8, 32'hFFFF_FFFF);
		expect_retire(0, 15, KIND_ALU, 1, 8, 32'h0000_0001);
		expect_retire(0, 16, KIND_ALU, 1, 9, 32'h0000_0005);
		expect_retire(0, 17, KIND_ALU, 1, 9, 32'h0000_0000);
		expect_retire(0, 18, KIND_STORE, 0, 0, 32'h0000_0E12);
		expect_retire(0, 19, KIND_LOAD, 1, 10, 32'h0000_0E12);
		// Negative immediate on a loaded nonzero value
		expect_retire(0, 20, KIND_ALU, 1, 10, 32'h0000_0E02);
		expect_retire(0, 21, KIND_HALT, 0, 0, 32'h0);
		// Branches, jumps and link
		// r1 starts from the cleared register file
		put_word(1, encode(OP_ALUI, FN_ADD, 1, 0, 16'h0007));
		put_word(1, encode(OP_CTRL, BEQZ, 2, 0, 16'h0002));
		put_word(1, encode(OP_ALUI, FN_ADD, 1, 0, 16'h0100));
		put_word(1, encode(OP_ALUI, FN_ADD, 1, 0, 16'h0200));
		put_word(1, encode(OP_CTRL, BEQZ, 1, 0, 16'h0005));
		put_word(1, encode(OP_ALUI, FN_ADD, 3, 0, 16'hFFFE));
		put_word(1, encode(OP_CTRL, BLTZ, 3, 0, 16'h0001));
		put_word(1, encode(OP_ALUI, FN_ADD, 3, 0, 16'h0040));
		put_word(1, encode(OP_CTRL, BLTZ, 1, 0, 16'h0003));
		put_word(1, encode(OP_CTRL, JAL, 0, 0, 16'd14));
		put_word(1, encode(OP_ALUI, FN_ADD, 4, 0, 16'h0001));
		put_word(1, encode(OP_ALUI, FN_ADD, 4, 0, 16'h0002));
		put_word(1, encode(OP_ALUI, FN_ADD, 4, 0, 16'h0003));
		put_word(1, encode(OP_ALUI, FN_ADD, 4, 0, 16'h0004));
		put_word(1, encode(OP_ALUI, FN_ADD, 31, 0, 16'h0005));
		put_word(1, encode(OP_CTRL, JMP, 0, 0, 16'd18));
		put_word(1, encode(OP_ALUI, FN_ADD, 5, 0, 16'h0001));
		put_word(1, encode(OP_ALUI, FN_ADD, 5, 0, 16'h0001));
		put_word(1, encode(OP_ALUI, FN_ADD, 5, 0, 16'h0022));
		put_word(1, encode(OP_CTRL, HALT, 0, 0, 16'h0));
		expect_retire(1, 0, KIND_ALU, 1, 1, 32'h0000_0007);
		expect_retire(1, 1, KIND_CTRL, 0, 0, 32'h0);
		expect_retire(1, 4, KIND_CTRL, 0, 0, 32'h0);
		expect_retire(1, 5, KIND_ALU, 1, 3, 32'hFFFF_FFFE);
		expect_retire(1, 6, KIND_CTRL, 0, 0, 32'h0);
		expect_retire(1, 8, KIND_CTRL, 0, 0, 32'h0);
		expect_retire(1, 9, KIND_CTRL, 1, 31, 32'h0000_000A);
		expect_retire(1, 14, KIND_ALU, 1, 31, 32'h0000_000F);
		expect_retire(1, 15, KIND_CTRL, 0, 0, 32'h0);
		expect_retire(1, 18, KIND_ALU, 1, 5, 32'h0000_0022);
		expect_retire(1, 19, KIND_HALT, 0, 0, 32'h0);
	endtask

	// Reset, load, idle, run until halted
	task automatic run_program(input int p);
		int addr;
		int idle;
		addr      = 0;
		exp_first = -1;
		@(negedge clk);
		rst = 1'b1;
		run = 1'b0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_words; i++)
		begin
			if (word_prog[i] == p)
			begin
				prog_we   = 1'b1;
				prog_addr = addr[PC_W-1:0];
				prog_data = words[i];
				addr++;
				@(negedge clk);
			end
		end
		prog_we = 1'b0;
		for (int i = 0; i < n_exp; i++)
		begin
			if (exp_prog[i] == p)
			begin
				if (exp_first < 0)
					exp_first = i;
				exp_last = i + 1;
			end
		end
		idle = $urandom % 8;
		repeat (idle) @(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		run   = 1'b1;
		while (!halted)
			@(negedge clk);
		// Room for any stray retirement
		repeat (4) @(negedge clk);
		check_end = 1'b1;
		@(negedge clk);
		check_end = 1'b0;
		run       = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Timeout and main sequence
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		rst       = 1'b1;
		run       = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		start     = 1'b0;
		check_end = 1'b0;
		report    = 1'b0;
		exp_first = 0;
		exp_last  = 0;
		void'($urandom(6152));
		fill_table();
		limit = 10 * n_words + 100;
		run_program(0);
		run_program(1);
		report = 1'b1;
		@(negedge clk);
		report = 1'b0;
		@(negedge clk);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
